// File: hdl/br_pkg.sv
`default_nettype none

////////////////////
// branch prediction shared definitions
////////////////////

package br_pkg;

    // word address width
    // byte address bits [1:0] are dropped before the front end
    localparam int pc_w = 30;

    // branch kind as stored in the btb and reported by the branch unit
    // br_none also means "no update this cycle" on the update port
    typedef enum logic [1:0] {
        // not a branch, or btb miss
        br_none = 2'b00,
        // conditional, direction from the pht
        br_cond = 2'b01,
        // call, always taken
        br_call = 2'b10,
        // return, always taken
        br_ret  = 2'b11
    } br_type_e;

endpackage

`default_nettype wire

// File: hdl/br_pre_top.sv
`timescale 1ns/1ps
`default_nettype none

// branch prediction front end
// two slots per cycle: slot 0 at pc, slot 1 at pc + 1
// even addresses live in bank 0, odd in bank 1
module br_pre_top #(
    parameter int btb_idx_w = 6,
    parameter int pht_idx_w = 7
) (
    input  wire logic                        clk,
    input  wire logic                        arst_n,

    // prediction side, combinational
    input  wire logic [br_pkg::pc_w-1:0]     pc,
    output logic      [br_pkg::pc_w-1:0]     pred0_br_target,
    output br_pkg::br_type_e                 pred0_br_type,
    output logic      [br_pkg::pc_w-1:0]     pred1_br_target,
    output br_pkg::br_type_e                 pred1_br_type,

    // update side, level signals from the branch unit
    input  wire logic [br_pkg::pc_w-1:0]     branch_pc,
    input  br_pkg::br_type_e                 branch_br_type,
    input  wire logic [br_pkg::pc_w-1:0]     branch_br_target,
    // resolved direction, counters only
    input  wire logic                        branch_jump
);

    import br_pkg::*;

    ////////////////////
    // bank steering
    ////////////////////

    logic [pc_w-1:0] pc_inc;
    logic [pc_w-1:0] even_pc;
    logic [pc_w-1:0] odd_pc;

    // second slot address, wraps at 2^30
    assign pc_inc = pc + pc_w'(1);

    // one of pc / pc+1 is even, the other odd
    assign even_pc = pc[0] ? pc_inc : pc;
    assign odd_pc  = pc[0] ? pc     : pc_inc;

    ////////////////////
    // tables
    ////////////////////

    br_type_e        btb0_type;
    logic [pc_w-1:0] btb0_target;
    br_type_e        btb1_type;
    logic [pc_w-1:0] btb1_target;
    logic            pht0_taken;
    logic            pht1_taken;

    // even bank
    btb #(
        .btb_idx_w (btb_idx_w),
        .bank      (1'b0)
    ) u_btb0 (
        .clk              (clk),
        .arst_n           (arst_n),
        .lookup_pc        (even_pc),
        .br_type          (btb0_type),
        .br_target        (btb0_target),
        .branch_pc        (branch_pc),
        .branch_br_type   (branch_br_type),
        .branch_br_target (branch_br_target)
    );

    // odd bank
    btb #(
        .btb_idx_w (btb_idx_w),
        .bank      (1'b1)
    ) u_btb1 (
        .clk              (clk),
        .arst_n           (arst_n),
        .lookup_pc        (odd_pc),
        .br_type          (btb1_type),
        .br_target        (btb1_target),
        .branch_pc        (branch_pc),
        .branch_br_type   (branch_br_type),
        .branch_br_target (branch_br_target)
    );

    // counters, same split
    pht #(
        .pht_idx_w (pht_idx_w),
        .bank      (1'b0)
    ) u_pht0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .lookup_pc      (even_pc),
        .taken          (pht0_taken),
        .branch_pc      (branch_pc),
        .branch_br_type (branch_br_type),
        .branch_jump    (branch_jump)
    );

    pht #(
        .pht_idx_w (pht_idx_w),
        .bank      (1'b1)
    ) u_pht1 (
        .clk            (clk),
        .arst_n         (arst_n),
        .lookup_pc      (odd_pc),
        .taken          (pht1_taken),
        .branch_pc      (branch_pc),
        .branch_br_type (branch_br_type),
        .branch_jump    (branch_jump)
    );

    ////////////////////
    // target select
    ////////////////////

    logic [pc_w-1:0] bank0_target;
    logic [pc_w-1:0] bank1_target;

    // cond branch predicted not taken falls through to its own address + 1
    // everything else takes the btb target (0 on a miss)
    assign bank0_target = (btb0_type == br_cond && !pht0_taken) ? even_pc + pc_w'(1)
                                                                : btb0_target;
    assign bank1_target = (btb1_type == br_cond && !pht1_taken) ? odd_pc + pc_w'(1)
                                                                : btb1_target;

    ////////////////////
    // slot order
    ////////////////////

    // even pc: slot 0 from bank 0
    // odd pc: banks swap
    always_comb begin
        if (pc[0]) begin
            pred0_br_type   = btb1_type;
            pred0_br_target = bank1_target;
            pred1_br_type   = btb0_type;
            pred1_br_target = bank0_target;
        end else begin
            pred0_br_type   = btb0_type;
            pred0_br_target = bank0_target;
            pred1_br_type   = btb1_type;
            pred1_br_target = bank1_target;
        end
    end

endmodule

`default_nettype wire

// File: hdl/btb.sv
`timescale 1ns/1ps
`default_nettype none

// one bank of the branch target buffer
// direct mapped, indexed from address bit 1 upward
module btb #(
    parameter int btb_idx_w = 6,
    // value of address bit 0 held by this bank
    parameter bit bank = 1'b0
) (
    input  wire logic                        clk,
    input  wire logic                        arst_n,

    // lookup port
    input  wire logic [br_pkg::pc_w-1:0]     lookup_pc,
    output br_pkg::br_type_e                 br_type,
    output logic      [br_pkg::pc_w-1:0]     br_target,

    // update port, straight from the branch unit
    input  wire logic [br_pkg::pc_w-1:0]     branch_pc,
    input  br_pkg::br_type_e                 branch_br_type,
    input  wire logic [br_pkg::pc_w-1:0]     branch_br_target
);

    import br_pkg::*;

    ////////////////////
    // geometry
    ////////////////////

    // entries per bank
    localparam int depth = 1 << btb_idx_w;
    // tag is everything above the index
    // bit 0 is implied by the bank
    localparam int tag_w = pc_w - btb_idx_w - 1;

    ////////////////////
    // storage
    ////////////////////

    // one valid bit per entry
    logic [depth-1:0]     valid_q;
    // payload arrays
    logic [tag_w-1:0]     tag_q    [depth];
    br_type_e             type_q   [depth];
    logic [pc_w-1:0]      target_q [depth];

    ////////////////////
    // lookup
    ////////////////////

    logic [btb_idx_w-1:0] rd_idx;
    logic [tag_w-1:0]     rd_tag;
    logic                 rd_hit;

    // index and tag slices of the lookup address
    assign rd_idx = lookup_pc[btb_idx_w:1];
    assign rd_tag = lookup_pc[pc_w-1:btb_idx_w+1];

    // hit needs a live entry with the same tag
    assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // miss reads as no branch with a zero target
    assign br_type   = rd_hit ? type_q[rd_idx]   : br_none;
    assign br_target = rd_hit ? target_q[rd_idx] : '0;

    ////////////////////
    // update
    ////////////////////

    logic [btb_idx_w-1:0] wr_idx;
    logic [tag_w-1:0]     wr_tag;
    logic                 wr_en;

    assign wr_idx = branch_pc[btb_idx_w:1];
    assign wr_tag = branch_pc[pc_w-1:btb_idx_w+1];

    // any real branch type is an update
    // only the bank owning branch_pc parity takes it
    assign wr_en = (branch_br_type != br_none) && (branch_pc[0] == bank);

    // valid bits
    // cleared by reset, set on write, never cleared otherwise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // payload write
    // overwrites the slot whatever tag it held before
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            type_q[wr_idx]   <= branch_br_type;
            target_q[wr_idx] <= branch_br_target;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pht.sv
`timescale 1ns/1ps
`default_nettype none

// one bank of 2-bit direction counters
// untagged, indexed from address bit 1 upward
module pht #(
    parameter int pht_idx_w = 7,
    // value of address bit 0 held by this bank
    parameter bit bank = 1'b0
) (
    input  wire logic                        clk,
    input  wire logic                        arst_n,

    // lookup port
    input  wire logic [br_pkg::pc_w-1:0]     lookup_pc,
    output logic                             taken,

    // update port, straight from the branch unit
    input  wire logic [br_pkg::pc_w-1:0]     branch_pc,
    input  br_pkg::br_type_e                 branch_br_type,
    input  wire logic                        branch_jump
);

    import br_pkg::*;
    import pht_pkg::*;

    // counters per bank
    localparam int depth = 1 << pht_idx_w;

    // one step toward strong_t or strong_nt
    // sticks at either end
    function automatic pht_state_e sat_step(input pht_state_e cur, input logic up);
        pht_state_e nxt;
        nxt = cur;
        case (cur)
            strong_nt: nxt = up ? weak_nt  : strong_nt;
            weak_nt:   nxt = up ? weak_t   : strong_nt;
            weak_t:    nxt = up ? strong_t : weak_nt;
            strong_t:  nxt = up ? strong_t : weak_t;
            default:   nxt = pht_reset_state;
        endcase
        return nxt;
    endfunction

    ////////////////////
    // counter array
    ////////////////////

    pht_state_e           cnt_q [depth];

    ////////////////////
    // lookup
    ////////////////////

    logic [pht_idx_w-1:0] rd_idx;

    assign rd_idx = lookup_pc[pht_idx_w:1];

    // upper half of the counter range
    assign taken = (cnt_q[rd_idx] == weak_t) || (cnt_q[rd_idx] == strong_t);

    ////////////////////
    // update
    ////////////////////

    logic [pht_idx_w-1:0] wr_idx;
    logic                 wr_en;
    pht_state_e           wr_next;

    assign wr_idx = branch_pc[pht_idx_w:1];

    // conditional branches only, and only in the owning bank
    assign wr_en = (branch_br_type == br_cond) && (branch_pc[0] == bank);

    // resolved direction picks the step
    assign wr_next = sat_step(cnt_q[wr_idx], branch_jump);

    // whole array returns to the reset state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                cnt_q[i] <= pht_reset_state;
            end
        end else if (wr_en) begin
            cnt_q[wr_idx] <= wr_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pht_pkg.sv
`default_nettype none

////////////////////
// direction counter definitions
////////////////////

package pht_pkg;

    // 2-bit saturating counter
    // upper half predicts taken
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } pht_state_e;

    // state of every counter out of reset
    // one taken update is enough to flip the prediction
    localparam pht_state_e pht_reset_state = weak_nt;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the branch prediction testbench with verilator
# exit status is nonzero when the simulation ends in $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_br_pre \
    -o tb_br_pre

./obj_dir/tb_br_pre

// File: src.f
hdl/br_pkg.sv
hdl/pht_pkg.sv
hdl/btb.sv
hdl/pht.sv
hdl/br_pre_top.sv
testbench/br_pre_assert.sv
testbench/tb_br_pre.sv

// File: testbench/br_pre_assert.sv
`timescale 1ns/1ps
`default_nettype none

// output sanity and counter stability on the prediction front end
module br_pre_assert #(
    parameter int pht_idx_w = 7
) (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic [br_pkg::pc_w-1:0] pred0_br_target,
    input  br_pkg::br_type_e             pred0_br_type,
    input  wire logic [br_pkg::pc_w-1:0] pred1_br_target,
    input  br_pkg::br_type_e             pred1_br_type,
    input  br_pkg::br_type_e             branch_br_type,
    // counter arrays of both pht banks
    input  pht_pkg::pht_state_e          cnt0 [1 << pht_idx_w],
    input  pht_pkg::pht_state_e          cnt1 [1 << pht_idx_w]
);

    import br_pkg::*;
    import pht_pkg::*;

    localparam int depth = 1 << pht_idx_w;

    // counters as they stood one edge earlier
    pht_state_e cnt0_q [depth];
    pht_state_e cnt1_q [depth];
    logic       cnt_same;

    always_ff @(posedge clk) begin
        cnt0_q <= cnt0;
        cnt1_q <= cnt1;
    end

    always_comb begin
        cnt_same = 1'b1;
        for (int i = 0; i < depth; i++) begin
            if (cnt0[i] != cnt0_q[i] || cnt1[i] != cnt1_q[i]) begin
                cnt_same = 1'b0;
            end
        end
    end

    ////////////////////
    // properties
    ////////////////////

    a_slot0_none_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (pred0_br_type == br_none) |-> (pred0_br_target == '0))
        else $error("slot 0 has no branch but a nonzero target");

    a_slot1_none_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (pred1_br_type == br_none) |-> (pred1_br_target == '0))
        else $error("slot 1 has no branch but a nonzero target");

    a_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({pred0_br_type, pred0_br_target, pred1_br_type, pred1_br_target}))
        else $error("prediction outputs carry unknown bits");

    // idle update port, counters hold
    a_idle_keeps_cnt: assert property (@(posedge clk) disable iff (!arst_n)
        (branch_br_type == br_none) |=> cnt_same)
        else $error("counter changed on an update of type br_none");

endmodule

bind br_pre_top br_pre_assert #(
    .pht_idx_w (pht_idx_w)
) u_assert (
    .clk             (clk),
    .arst_n          (arst_n),
    .pred0_br_target (pred0_br_target),
    .pred0_br_type   (pred0_br_type),
    .pred1_br_target (pred1_br_target),
    .pred1_br_type   (pred1_br_type),
    .branch_br_type  (branch_br_type),
    .cnt0            (u_pht0.cnt_q),
    .cnt1            (u_pht1.cnt_q)
);

`default_nettype wire

// File: testbench/tb_br_pre.sv
`timescale 1ns/1ps
`default_nettype none

module tb_br_pre;

    import br_pkg::*;

    localparam int  btb_idx_w  = 6;
    localparam int  pht_idx_w  = 7;
    localparam int  half_per   = 10;
    localparam time skew       = 2;
    // polls of 1 ns before a missing edge counts as a stall
    localparam int  rise_limit = 40;

    ////////////////////
    // dut hookup
    ////////////////////

    logic            clk;
    logic            arst_n;
    logic [pc_w-1:0] pc;
    logic [pc_w-1:0] pred0_br_target;
    br_type_e        pred0_br_type;
    logic [pc_w-1:0] pred1_br_target;
    br_type_e        pred1_br_type;
    logic [pc_w-1:0] branch_pc;
    br_type_e        branch_br_type;
    logic [pc_w-1:0] branch_br_target;
    logic            branch_jump;

    br_pre_top #(
        .btb_idx_w (btb_idx_w),
        .pht_idx_w (pht_idx_w)
    ) u_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .pc               (pc),
        .pred0_br_target  (pred0_br_target),
        .pred0_br_type    (pred0_br_type),
        .pred1_br_target  (pred1_br_target),
        .pred1_br_type    (pred1_br_type),
        .branch_pc        (branch_pc),
        .branch_br_type   (branch_br_type),
        .branch_br_target (branch_br_target),
        .branch_jump      (branch_jump)
    );

    ////////////////////
    // stimulus table
    ////////////////////

    // free[1] puts the drawn tag bits on the update pc, free[0] on the lookup pc
    typedef struct packed {
        logic [pc_w-1:0] upd_pc;
        br_type_e        upd_type;
        logic [pc_w-1:0] upd_target;
        logic            upd_jump;
        logic [1:0]      free;
        logic [pc_w-1:0] pred_pc;
        br_type_e        exp0_type;
        logic [pc_w-1:0] exp0_target;
        br_type_e        exp1_type;
        logic [pc_w-1:0] exp1_target;
    } row_t;

    row_t            rows [$];
    int              seed;
    logic [pc_w-1:0] free_hi;
    int unsigned     rise_cnt;
    time             rise_stamp;

    task automatic add_row(input logic [pc_w-1:0] upd_pc, input br_type_e upd_type,
                           input logic [pc_w-1:0] upd_target, input logic upd_jump,
                           input logic [1:0] free, input logic [pc_w-1:0] pred_pc,
                           input br_type_e e0_type, input logic [pc_w-1:0] e0_target,
                           input br_type_e e1_type, input logic [pc_w-1:0] e1_target);
        rows.push_back({upd_pc, upd_type, upd_target, upd_jump, free, pred_pc,
                        e0_type, e0_target, e1_type, e1_target});
    endtask

    // clock, 20 ns
    initial begin
        clk = 1'b0;
        forever begin
            #half_per;
            clk = ~clk;
        end
    end

    always @(posedge clk) begin
        rise_cnt   = rise_cnt + 1;
        rise_stamp = $time;
    end

    // next rising edge, then settle at edge + skew
    task automatic wait_rise(input string what);
        int unsigned start;
        int          t;
        time         settle;
        start = rise_cnt;
        t     = 0;
        while (rise_cnt == start && t < rise_limit) begin
            #1;
            t++;
        end
        if (rise_cnt == start) begin
            $display("timeout: no rising clock edge while waiting for %s", what);
            $display("TEST FAIL");
            $fatal(1, "clock stalled");
        end
        settle = rise_stamp + skew - $time;
        #(settle);
    endtask

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_type(input string name, input br_type_e exp, input br_type_e act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %s got %s", $time, name, exp.name(), act.name());
            $display("TEST FAIL");
            $fatal(1, "type mismatch on %s", name);
        end
    endtask

    task automatic check_target(input string name, input logic [pc_w-1:0] exp,
                                input logic [pc_w-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "target mismatch on %s", name);
        end
    endtask

    initial begin
        row_t            r;
        logic [31:0]     rnd;
        logic [pc_w-1:0] upd_pc;
        logic [pc_w-1:0] pred_pc;
        arst_n           = 1'b0;
        pc               = '0;
        branch_pc        = '0;
        branch_br_type   = br_none;
        branch_br_target = '0;
        branch_jump      = 1'b0;
        rise_cnt         = 0;
        seed             = 32'h4a8a_cbe0;
        // top bit forced so the drawn tag never equals tag 0
        rnd              = $random(seed);
        free_hi          = {1'b1, rnd[11:0], 17'b0};

        // empty tables, even / odd / drawn / all-ones pc
        add_row('0, br_none, '0, 1'b0, 2'b00, 30'h10, br_none, '0, br_none, '0);
        add_row('0, br_none, '0, 1'b0, 2'b00, 30'h25, br_none, '0, br_none, '0);
        add_row('0, br_none, '0, 1'b0, 2'b01, '0, br_none, '0, br_none, '0);
        add_row('0, br_none, '0, 1'b0, 2'b00, 30'h3fff_ffff, br_none, '0, br_none, '0);
        // call even, ret odd neighbour
        add_row(30'h40, br_call, 30'h1234, 1'b0, 2'b00, 30'h40, br_call, 30'h1234, br_none, '0);
        add_row(30'h41, br_ret, 30'h2000, 1'b0, 2'b00, 30'h40, br_call, 30'h1234, br_ret, 30'h2000);
        add_row('0, br_none, '0, 1'b0, 2'b00, 30'h41, br_ret, 30'h2000, br_none, '0);
        // alias with a drawn tag biases the shared counter to weak_t
        add_row(30'h10, br_cond, 30'h3000, 1'b1, 2'b11, 30'h10, br_cond, 30'h3000, br_none, '0);
        // back to weak_nt, entry now at tag 0
        add_row(30'h10, br_cond, 30'h3000, 1'b0, 2'b00, 30'h10, br_cond, 30'h11, br_none, '0);
        add_row(30'h10, br_cond, 30'h3000, 1'b1, 2'b00, 30'h10, br_cond, 30'h3000, br_none, '0);
        add_row(30'h10, br_cond, 30'h3000, 1'b1, 2'b00, 30'h10, br_cond, 30'h3000, br_none, '0);
        add_row(30'h10, br_cond, 30'h3000, 1'b1, 2'b00, 30'h10, br_cond, 30'h3000, br_none, '0);
        add_row(30'h10, br_cond, 30'h3000, 1'b0, 2'b00, 30'h10, br_cond, 30'h3000, br_none, '0);
        add_row(30'h10, br_cond, 30'h3000, 1'b0, 2'b00, 30'h10, br_cond, 30'h11, br_none, '0);
        add_row(30'h10, br_cond, 30'h3000, 1'b0, 2'b00, 30'h10, br_cond, 30'h11, br_none, '0);
        // no-op update, then one taken only reaches weak_nt
        add_row(30'h10, br_none, 30'h7777, 1'b1, 2'b00, 30'h10, br_cond, 30'h11, br_none, '0);
        add_row(30'h10, br_cond, 30'h3000, 1'b1, 2'b00, 30'h10, br_cond, 30'h11, br_none, '0);
        // eviction by a drawn tag at the same index
        add_row(30'h60, br_call, 30'h5555, 1'b0, 2'b00, 30'h60, br_call, 30'h5555, br_none, '0);
        add_row(30'h60, br_ret, 30'h6666, 1'b0, 2'b10, 30'h60, br_none, '0, br_none, '0);
        add_row('0, br_none, '0, 1'b0, 2'b01, 30'h60, br_ret, 30'h6666, br_none, '0);
        // odd bank cond not taken, falls through in slot 1
        add_row(30'h2b, br_cond, 30'h4000, 1'b0, 2'b00, 30'h2a, br_none, '0, br_cond, 30'h2c);
        // wrap, slot 1 at address 0
        add_row('0, br_call, 30'habc, 1'b0, 2'b00, 30'h3fff_ffff, br_none, '0, br_call, 30'habc);
        add_row(30'h3fff_ffff, br_ret, 30'h111, 1'b0, 2'b00, 30'h3fff_ffff,
                br_ret, 30'h111, br_call, 30'habc);

        // 2 cycles of reset
        wait_rise("reset");
        wait_rise("reset");
        arst_n = 1'b1;

        foreach (rows[i]) begin
            r       = rows[i];
            upd_pc  = r.upd_pc | (r.free[1] ? free_hi : '0);
            pred_pc = r.pred_pc | (r.free[0] ? free_hi : '0);
            branch_pc        = upd_pc;
            branch_br_type   = r.upd_type;
            branch_br_target = r.upd_target;
            branch_jump      = r.upd_jump;
            wait_rise("update edge");
            // lookup cycle, update port idle
            branch_br_type = br_none;
            branch_jump    = 1'b0;
            pc             = pred_pc;
            wait_rise("lookup edge");
            check_type("pred0_br_type", r.exp0_type, pred0_br_type);
            check_target("pred0_br_target", r.exp0_target, pred0_br_target);
            check_type("pred1_br_type", r.exp1_type, pred1_br_type);
            check_target("pred1_br_target", r.exp1_target, pred1_br_target);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
